// File: cd_data_loader.f
source/host_io_pkg.sv
source/cd_pkg.sv
source/cd_header_parser.sv
source/cd_word_fifo.sv
source/cd_byte_serializer.sv
source/cd_data_loader.sv
verif/cd_data_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CD data loader testbench with Verilator

cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -j 0 --top-module cd_data_loader_tb \
	-f cd_data_loader.f -o sim_cd_data_loader > build.log 2>&1 &&
./obj_dir/sim_cd_data_loader > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verif/cd_data_loader_tb.sv
`timescale 1ns/100ps

module cd_data_loader_tb;

	import host_io_pkg::*;
	import cd_pkg::*;

	localparam int len_even     = 12;
	localparam int len_odd      = 9;
	localparam int len_extra    = 6;
	localparam int len_burst    = 40;
	localparam int test_cnt     = 5;
	localparam int quiet_cycles = 20;

	// Reset, then per test 4 cycles a byte plus 40, then slack
	localparam int cycle_limit = 16 + 4 * (len_even + len_odd + len_extra + len_burst)
		+ 40 * test_cnt + 200;

	logic        clk_sys;
	logic        reset;
	logic        download;
	host_index_t index;
	host_write_t host_wr;
	logic        ioctl_wait;
	cd_byte_t    cd_data;
	logic        cd_wr;
	logic        cd_data_end;
	logic        cd_dm;

	integer     seed;
	int         cycle       = 0;
	int         err_cnt     = 0;
	int         pass_cnt    = 0;
	int         fail_cnt    = 0;
	int         end_cnt     = 0;
	logic       wait_seen   = 1'b0;
	logic       strobe_last = 1'b0;
	logic [8:0] exp_head;

	// Expected bytes with bit 8 marking the final byte of a block
	logic [8:0] exp_q [$];

	cd_data_loader u_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.index       (index),
		.host_wr     (host_wr),
		.ioctl_wait  (ioctl_wait),
		.cd_data     (cd_data),
		.cd_wr       (cd_wr),
		.cd_data_end (cd_data_end),
		.cd_dm       (cd_dm)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#50 clk_sys = ~clk_sys;
		end
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Concurrent checks
	//////////////////////////////

	a_wr_gap: assert property (@(posedge clk_sys) disable iff (reset) cd_wr |=> !cd_wr)
		else begin
			$display("cd_wr was high in two consecutive cycles");
			err_cnt++;
		end

	// End pulse exactly one cycle after the final byte strobe
	a_end_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cd_data_end == $past(cd_wr && strobe_last))
		else begin
			$display("cd_data_end did not follow the final byte strobe by one cycle");
			err_cnt++;
		end

	a_reset_quiet: assert property (@(posedge clk_sys)
		(reset && cycle > 0) |-> (!cd_wr && !cd_data_end && !ioctl_wait))
		else begin
			$display("Output active during reset");
			err_cnt++;
		end

	// Byte monitor sampling mid cycle
	always @(negedge clk_sys) begin
		strobe_last = 1'b0;
		if (!reset) begin
			if (ioctl_wait) begin
				wait_seen = 1'b1;
			end
			if (cd_data_end) begin
				end_cnt++;
			end
			if (cd_wr && exp_q.size() == 0) begin
				$display("Unexpected byte strobe with cd_data %h", cd_data);
				err_cnt++;
			end else if (cd_wr) begin
				exp_head    = exp_q.pop_front();
				strobe_last = exp_head[8];
				a_byte: assert (cd_data == exp_head[7:0])
					else begin
						$display("MISMATCH cd_data expected %h actual %h", exp_head[7:0], cd_data);
						err_cnt++;
					end
			end
		end
	end

	//////////////////////////////
	// Host side tasks
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// One word held off while the buffer is full
	task automatic write_word(input logic [15:0] w);
		while (ioctl_wait) begin
			host_wr.wr = 1'b0;
			next_cycle();
		end
		host_wr.wr   = 1'b1;
		host_wr.word = w;
		next_cycle();
		host_wr.wr = 1'b0;
	endtask

	task automatic open_download(input host_index_t idx);
		index    = idx;
		download = 1'b1;
		next_cycle();
	endtask

	task automatic close_download();
		download = 1'b0;
		next_cycle();
	endtask

	// Header, random data words and surplus words after the count
	task automatic send_block(input logic dm, input int len, input int extra, input int gap);
		int          words;
		logic [15:0] w;
		cd_header_t  hdr;
		words   = (len + 1) / 2;
		hdr.dm  = dm;
		hdr.len = len[cd_len_w-1:0];
		open_download(cd_data_index);
		write_word(hdr);
		for (int k = 0; k < words + extra; k++) begin
			w = 16'($random(seed));
			if (2 * k < len) begin
				exp_q.push_back({(2 * k + 1 >= len), w[7:0]});
				if (2 * k + 1 < len) begin
					exp_q.push_back({(2 * k + 2 >= len), w[15:8]});
				end
			end
			write_word(w);
			idle(gap);
		end
		close_download();
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			next_cycle();
		end
		idle(4);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		a_value: assert (actual == expected)
			else begin
				$display("MISMATCH %s expected %h actual %h", name, expected, actual);
				err_cnt++;
			end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			pass_cnt++;
			$display("Test %s passed", name);
		end else begin
			fail_cnt++;
			$display("Test %s failed with %0d errors", name, err_cnt - err_before);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int err_before;
		int end_before;
		seed     = 69;
		reset    = 1'b1;
		download = 1'b0;
		index    = '0;
		host_wr  = '0;
		repeat (16) @(posedge clk_sys);
		#10;
		reset = 1'b0;

		err_before = err_cnt;
		check_value("cd_wr", cd_wr, 0);
		check_value("cd_data_end", cd_data_end, 0);
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("cd_dm", cd_dm, 0);
		open_download(cd_data_index);
		idle(quiet_cycles);
		close_download();
		check_value("cd_data_end count", end_cnt, 0);
		finish_test("reset_idle", err_before);

		err_before = err_cnt;
		end_before = end_cnt;
		send_block(1'b1, len_even, 0, 2);
		wait_drain();
		check_value("cd_dm", cd_dm, 1);
		check_value("cd_data_end count", end_cnt - end_before, 1);
		finish_test("even_block", err_before);

		err_before = err_cnt;
		end_before = end_cnt;
		send_block(1'b0, len_odd, 0, 1);
		wait_drain();
		check_value("cd_dm", cd_dm, 0);
		check_value("cd_data_end count", end_cnt - end_before, 1);
		finish_test("odd_block", err_before);

		// Surplus words, empty block, foreign index
		err_before = err_cnt;
		end_before = end_cnt;
		send_block(1'b1, len_extra, 3, 1);
		wait_drain();
		idle(quiet_cycles);
		send_block(1'b0, 0, 2, 1);
		idle(quiet_cycles);
		open_download(8'h03);
		write_word(16'h8004);
		write_word(16'h1234);
		write_word(16'h5678);
		close_download();
		idle(quiet_cycles);
		check_value("cd_dm", cd_dm, 0);
		check_value("cd_data_end count", end_cnt - end_before, 1);
		finish_test("ignored_words", err_before);

		err_before = err_cnt;
		end_before = end_cnt;
		wait_seen  = 1'b0;
		send_block(1'b1, len_burst, 0, 0);
		wait_drain();
		check_value("cd_data_end count", end_cnt - end_before, 1);
		a_wait_seen: assert (wait_seen)
			else begin
				$display("ioctl_wait never rose during the burst");
				err_cnt++;
			end
		finish_test("back_pressure", err_before);

		$display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: source/cd_data_loader.sv
`timescale 1ns/100ps

module cd_data_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     download,
	input  host_io_pkg::host_index_t index,
	input  host_io_pkg::host_write_t host_wr,
	output logic                     ioctl_wait,
	output cd_pkg::cd_byte_t         cd_data,
	output logic                     cd_wr,
	output logic                     cd_data_end,
	output logic                     cd_dm
);

	import cd_pkg::*;

	logic     push;
	logic     pop;
	logic     empty;
	cd_word_t push_word;
	cd_word_t pop_word;

	// Header decode and word selection
	cd_header_parser u_parser (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.download  (download),
		.index     (index),
		.host_wr   (host_wr),
		.cd_dm     (cd_dm),
		.push      (push),
		.push_word (push_word)
	);

	// Full buffer stalls the host
	cd_word_fifo u_fifo (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.push      (push),
		.push_word (push_word),
		.pop       (pop),
		.pop_word  (pop_word),
		.empty     (empty),
		.full      (ioctl_wait)
	);

	cd_byte_serializer u_serializer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pop_word    (pop_word),
		.empty       (empty),
		.pop         (pop),
		.cd_data     (cd_data),
		.cd_wr       (cd_wr),
		.cd_data_end (cd_data_end)
	);

endmodule

// File: source/cd_byte_serializer.sv
`timescale 1ns/100ps

module cd_byte_serializer (
	input  logic             clk_sys,
	input  logic             reset,
	input  cd_pkg::cd_word_t pop_word,
	input  logic             empty,
	output logic             pop,
	output cd_pkg::cd_byte_t cd_data,
	output logic             cd_wr,
	output logic             cd_data_end
);

	import cd_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_strobe,
		st_gap
	} state_t;

	state_t   state;
	cd_word_t word_q;
	logic     byte_hi;
	logic     word_done;

	// High byte is skipped for a single byte word
	assign word_done = byte_hi || word_q.single;

	assign pop         = (state == st_idle) && !empty;
	assign cd_wr       = state == st_strobe;
	assign cd_data     = word_q.data[byte_hi];
	assign cd_data_end = (state == st_gap) && word_done && word_q.last;

	//////////////////////////////
	// Strobe and gap FSM
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			byte_hi <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (!empty) begin
						state   <= st_strobe;
						byte_hi <= 1'b0;
					end
				end
				st_strobe: begin
					state <= st_gap;
				end
				st_gap: begin
					if (word_done) begin
						state <= st_idle;
					end else begin
						// Low byte sent so the high one follows
						state   <= st_strobe;
						byte_hi <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Holding register for the word being sent
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			word_q <= pop_word;
		end
	end

endmodule

// File: source/cd_word_fifo.sv
`timescale 1ns/100ps

module cd_word_fifo #(
	parameter int depth = cd_pkg::cd_fifo_depth
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             push,
	input  cd_pkg::cd_word_t push_word,
	input  logic             pop,
	output cd_pkg::cd_word_t pop_word,
	output logic             empty,
	output logic             full
);

	import cd_pkg::*;

	localparam int addr_w = $clog2(depth);

	cd_word_t          mem [depth];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0]   count;
	logic              do_push;
	logic              do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Storage
	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + addr_w'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + addr_w'(1);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + (addr_w + 1)'(1);
				2'b01: count <= count - (addr_w + 1)'(1);
				default: count <= count;
			endcase
		end
	end

	// Oldest entry always on the output
	assign pop_word = mem[rd_ptr];
	assign empty    = count == '0;
	assign full     = count == (addr_w + 1)'(depth);

endmodule

// File: source/cd_header_parser.sv
`timescale 1ns/100ps

module cd_header_parser (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     download,
	input  host_io_pkg::host_index_t index,
	input  host_io_pkg::host_write_t host_wr,
	output logic                     cd_dm,
	output logic                     push,
	output cd_pkg::cd_word_t         push_word
);

	import host_io_pkg::*;
	import cd_pkg::*;

	logic                active;
	logic                active_d;
	logic                start;
	logic                header_seen;
	logic                header_now;
	cd_header_t          header;
	logic [cd_len_w-1:0] word_cnt;
	logic [cd_len_w-1:0] word_nxt;
	logic [cd_len_w:0]   byte_pos;
	logic [cd_len_w:0]   block_len;

	//////////////////////////////
	// Download decode
	//////////////////////////////

	assign active = download && (index[5:0] == cd_data_index[5:0]);
	assign start  = active && !active_d;

	// Rising edge of a download forgets the old header at once
	assign header_now = header_seen && !start;

	// Byte offset of the current data word
	assign byte_pos  = {word_cnt, 1'b0};
	assign block_len = {1'b0, header.len};
	assign word_nxt  = word_cnt + cd_len_w'(1);

	// Words past the byte count are dropped
	assign push = active && host_wr.wr && header_now && (byte_pos < block_len);

	assign push_word.data   = host_wr.word;
	assign push_word.single = {word_cnt, 1'b1} == block_len;
	assign push_word.last   = {word_nxt, 1'b0} >= block_len;

	assign cd_dm = header.dm;

	//////////////////////////////
	// Header and word count
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d    <= 1'b0;
			header_seen <= 1'b0;
			header      <= '0;
			word_cnt    <= '0;
		end else begin
			active_d <= active;

			if (start) begin
				header_seen <= 1'b0;
				word_cnt    <= '0;
			end

			if (active && host_wr.wr) begin
				if (!header_now) begin
					// First word of the block
					header      <= cd_header_t'(host_wr.word);
					header_seen <= 1'b1;
					word_cnt    <= '0;
				end else if (push) begin
					word_cnt <= word_nxt;
				end
			end
		end
	end

endmodule

// File: source/cd_pkg.sv
package cd_pkg;

	//////////////////////////////
	// CD data block format
	//////////////////////////////

	// Byte count field of the header word
	localparam int cd_len_w = 15;

	// Words held between download and byte output
	localparam int cd_fifo_depth = 8;

	typedef logic [7:0] cd_byte_t;

	// First word of a block with dm in the top bit
	typedef struct packed {
		logic                dm;
		logic [cd_len_w-1:0] len;
	} cd_header_t;

	// Queued data word
	// single means only the low byte is valid
	// last marks the final word of the block
	typedef struct packed {
		cd_byte_t [1:0] data;
		logic           single;
		logic           last;
	} cd_word_t;

endpackage

// File: source/host_io_pkg.sv
package host_io_pkg;

	//////////////////////////////
	// Host download bus
	//////////////////////////////

	localparam int host_word_w  = 16;
	localparam int host_index_w = 8;

	// Only the low six bits of the CD data block index are compared
	localparam logic [host_index_w-1:0] cd_data_index = 8'd2;

	typedef logic [host_index_w-1:0] host_index_t;

	// One host write with a single cycle wr strobe
	typedef struct packed {
		logic                   wr;
		logic [host_word_w-1:0] word;
	} host_write_t;

endpackage
